// File: verif/blit_fifo_testdata.txt
# clear mode enqueue enqueue_count enqueue_data dequeue dequeue_count clk_en
#   check_data exp_dequeue_data exp_avail_count exp_free_count (data in hex, rest decimal)
# After reset in 2bpp
0 0 0 0  00000000 0 0  1 1 00000000 0  32
# 2bpp round trip, the two words fill the whole ring
0 0 1 16 1B2D4E87 0 0  1 1 00000000 16 32
0 0 1 16 C6F0935A 0 0  1 1 00000000 32 16
0 0 0 0  00000000 0 0  1 1 00000000 32 0
0 0 0 0  00000000 0 0  1 1 00000000 32 0
0 0 0 0  00000000 1 16 1 1 1B2D4E87 16 0
0 0 0 0  00000000 1 16 1 1 C6F0935A 0  16
0 0 0 0  00000000 0 0  1 1 C6F0935A 0  32
# Odd partial transfers that cross the end of the ring
0 0 1 13 A5F03C96 0 0  1 1 C6F0935A 13 32
0 0 1 13 4B7E21D8 0 0  1 1 C6F0935A 26 19
0 0 0 0  00000000 0 0  1 1 C6F0935A 26 6
0 0 0 0  00000000 1 11 1 1 A5F03C92 15 6
0 0 0 0  00000000 0 0  1 1 A5F03C92 15 17
0 0 1 13 96E1C73F 0 0  1 1 A5F03C92 28 17
0 0 0 0  00000000 0 0  1 1 A5F03C92 28 4
0 0 0 0  00000000 1 9  1 1 24B7E21E 19 4
0 0 0 0  00000000 1 9  1 1 88796E1C 10 13
0 0 0 0  00000000 1 7  1 1 B871C0F2 3  22
0 0 0 0  00000000 1 3  1 1 703C92DF 0  29
0 0 0 0  00000000 0 0  1 1 703C92DF 0  32
# Strobes with CLK_EN low change nothing
0 0 1 4  FFFFFFFF 1 2  0 1 703C92DF 0  32
0 0 1 16 FFFFFFFF 1 16 0 1 703C92DF 0  32
# Clear in the middle of a stream, also with CLK_EN low, then 4bpp
0 0 1 5  12345678 0 0  1 1 703C92DF 5  32
1 1 0 0  00000000 0 0  0 1 00000000 0  0
0 1 0 0  00000000 0 0  1 1 00000000 0  16
0 1 1 8  0F1E2D3C 0 0  1 1 00000000 8  16
0 1 0 0  00000000 0 0  1 1 00000000 8  8
0 1 0 0  00000000 1 8  1 1 0F1E2D3C 0  8
# 8bpp
1 2 0 0  00000000 0 0  1 1 00000000 0  0
0 2 0 0  00000000 0 0  1 1 00000000 0  8
0 2 1 4  DEADBEEF 0 0  1 1 00000000 4  8
0 2 0 0  00000000 0 0  1 1 00000000 4  4
0 2 0 0  00000000 1 4  1 1 DEADBEEF 0  4
# 16bpp, the last word shows half a pixel pair and older ring content
1 3 0 0  00000000 0 0  1 1 00000000 0  0
0 3 0 0  00000000 0 0  1 1 00000000 0  4
0 3 1 2  5AA5C33C 0 0  1 1 00000000 2  4
0 3 0 0  00000000 0 0  1 1 00000000 2  2
0 3 0 0  00000000 1 2  1 1 5AA5C33C 0  2
0 3 0 0  00000000 0 0  1 1 5AA5C33C 0  4
0 3 1 1  13579BDF 0 0  1 1 5AA5C33C 1  4
0 3 0 0  00000000 0 0  1 1 5AA5C33C 1  3
0 3 0 0  00000000 1 1  1 1 1357796E 0  3
0 3 0 0  00000000 0 0  1 1 1357796E 0  4

// File: sim.f
hw/blit_fifo_pkg.sv
hw/blit_enqueue_stage.sv
hw/blit_slice_cell.sv
hw/blit_dequeue_stage.sv
hw/blit_fifo_level.sv
hw/blit_fifo.sv
verif/blit_fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the blit FIFO testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project root"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module blit_fifo_tb \
    --Mdir obj_dir -o blit_fifo_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/blit_fifo_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi

// File: verif/blit_fifo_tb.sv
`timescale 1ns/1ps

module blit_fifo_tb
    import blit_fifo_pkg::*;
();

    localparam int DEPTH        = 32;
    localparam int LVL_W        = $clog2(DEPTH) + 1;
    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 1;
    localparam int MAX_LINES    = 200;

    // One line of the data file, the stimulus of a cycle and the outputs after its edge
    typedef struct packed {
        logic               clear;
        logic [1:0]         mode;
        logic               enqueue;
        slice_count_t       enqueue_count;
        logic [WORD_W-1:0]  enqueue_data;
        logic               dequeue;
        slice_count_t       dequeue_count;
        logic               clk_en;
        logic               check_data;
        logic [WORD_W-1:0]  exp_data;
        logic [LVL_W-1:0]   exp_avail;
        logic [LVL_W-1:0]   exp_free;
    } test_vector_t;

    logic               CLK;
    logic               RESET_n;
    logic               CLK_EN;
    logic               clear;
    color_mode_e        color_mode;
    logic               enqueue;
    slice_count_t       enqueue_count;
    logic [WORD_W-1:0]  enqueue_data;
    logic               dequeue;
    slice_count_t       dequeue_count;
    logic [WORD_W-1:0]  dequeue_data;
    logic [LVL_W-1:0]   avail_count;
    logic [LVL_W-1:0]   free_count;

    int data_errors;
    int avail_errors;
    int free_errors;
    int other_errors;

    blit_fifo #(
        .DEPTH(DEPTH)
    ) blit_fifo_i (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLK_EN        (CLK_EN),
        .clear         (clear),
        .color_mode    (color_mode),
        .enqueue       (enqueue),
        .enqueue_count (enqueue_count),
        .enqueue_data  (enqueue_data),
        .dequeue       (dequeue),
        .dequeue_count (dequeue_count),
        .dequeue_data  (dequeue_data),
        .avail_count   (avail_count),
        .free_count    (free_count)
    );

    initial begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    function automatic bit in_range(input int value, input int hi);
        return (value >= 0) && (value <= hi);
    endfunction

    // Returns 0 for a comment or blank line, 1 for a vector and 2 for a broken line
    function automatic int parse_vector(input string text, output test_vector_t vec);
        int          n;
        int          f_clear;
        int          f_mode;
        int          f_enq;
        int          f_ecnt;
        int          f_deq;
        int          f_dcnt;
        int          f_en;
        int          f_chk;
        int          f_avail;
        int          f_free;
        logic [31:0] f_edata;
        logic [31:0] f_xdata;

        vec = '0;
        if (text.len() == 0 || text.getc(0) == "#" || text.getc(0) == "\n") begin
            return 0;
        end
        n = $sscanf(text, "%d %d %d %d %h %d %d %d %d %h %d %d",
                    f_clear, f_mode, f_enq, f_ecnt, f_edata, f_deq, f_dcnt,
                    f_en, f_chk, f_xdata, f_avail, f_free);
        if (n != 12) begin
            return 2;
        end
        if (!in_range(f_clear, 1) || !in_range(f_mode, 3) || !in_range(f_enq, 1) ||
            !in_range(f_ecnt, LANES) || !in_range(f_deq, 1) || !in_range(f_dcnt, LANES) ||
            !in_range(f_en, 1) || !in_range(f_chk, 1) || !in_range(f_avail, DEPTH) ||
            !in_range(f_free, DEPTH)) begin
            return 2;
        end
        vec.clear         = f_clear[0];
        vec.mode          = f_mode[1:0];
        vec.enqueue       = f_enq[0];
        vec.enqueue_count = slice_count_t'(f_ecnt);
        vec.enqueue_data  = f_edata;
        vec.dequeue       = f_deq[0];
        vec.dequeue_count = slice_count_t'(f_dcnt);
        vec.clk_en        = f_en[0];
        vec.check_data    = f_chk[0];
        vec.exp_data      = f_xdata;
        vec.exp_avail     = LVL_W'(f_avail);
        vec.exp_free      = LVL_W'(f_free);
        return 1;
    endfunction

    task automatic apply_vector(input test_vector_t vec);
        clear         = vec.clear;
        color_mode    = color_mode_e'(vec.mode);
        enqueue       = vec.enqueue;
        enqueue_count = vec.enqueue_count;
        enqueue_data  = vec.enqueue_data;
        dequeue       = vec.dequeue;
        dequeue_count = vec.dequeue_count;
        CLK_EN        = vec.clk_en;
    endtask

    task automatic check_outputs(input test_vector_t vec, input int line_no);
        if (vec.check_data) begin
            assert (dequeue_data === vec.exp_data) else begin
                data_errors++;
                $display("[ERROR] %0d ns, line %0d: dequeue_data expected %08h, got %08h",
                         $time, line_no, vec.exp_data, dequeue_data);
            end
        end
        assert (avail_count === vec.exp_avail) else begin
            avail_errors++;
            $display("[ERROR] %0d ns, line %0d: avail_count expected %0d, got %0d",
                     $time, line_no, vec.exp_avail, avail_count);
        end
        assert (free_count === vec.exp_free) else begin
            free_errors++;
            $display("[ERROR] %0d ns, line %0d: free_count expected %0d, got %0d",
                     $time, line_no, vec.exp_free, free_count);
        end
    endtask

    // Inputs settle just after an edge, outputs are sampled just after the next one
    task automatic run_cycle(input test_vector_t vec, input int line_no);
        apply_vector(vec);
        @(posedge CLK);
        #SAMPLE_DELAY;
        check_outputs(vec, line_no);
        #(DRIVE_DELAY - SAMPLE_DELAY);
    endtask

    initial begin
        int           fd;
        int           status;
        int           line_no;
        int           vectors;
        bit           timed_out;
        string        text;
        test_vector_t vec;

        RESET_n       = 1'b0;
        CLK_EN        = 1'b0;
        clear         = 1'b0;
        color_mode    = CLRM_2BPP;
        enqueue       = 1'b0;
        enqueue_count = '0;
        enqueue_data  = '0;
        dequeue       = 1'b0;
        dequeue_count = '0;
        data_errors   = 0;
        avail_errors  = 0;
        free_errors   = 0;
        other_errors  = 0;
        timed_out     = 1'b0;
        vectors       = 0;
        line_no       = 0;

        fd = $fopen("verif/blit_fifo_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the data file verif/blit_fifo_testdata.txt");
        end

        repeat (2) @(posedge CLK);
        #DRIVE_DELAY;
        RESET_n = 1'b1;

        if (fd != 0) begin
            while (!$feof(fd) && !timed_out) begin
                line_no++;
                if (line_no > MAX_LINES) begin
                    timed_out = 1'b1;
                    other_errors++;
                    $display("Timeout: data file not finished after %0d lines", MAX_LINES);
                end else if ($fgets(text, fd) != 0) begin
                    status = parse_vector(text, vec);
                    if (status == 2) begin
                        other_errors++;
                        $display("Malformed line %0d in the data file: %s", line_no, text);
                    end else if (status == 1) begin
                        vectors++;
                        run_cycle(vec, line_no);
                    end
                end
            end
            $fclose(fd);
            if (vectors == 0) begin
                other_errors++;
                $display("The data file holds no test vectors");
            end
        end

        $display("Errors: %0d dequeue_data, %0d avail_count, %0d free_count, %0d other",
                 data_errors, avail_errors, free_errors, other_errors);
        if (data_errors + avail_errors + free_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: hw/blit_fifo.sv
`timescale 1ns/1ps

module blit_fifo
    import blit_fifo_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     CLK_EN,
    input  logic                     clear,
    input  color_mode_e              color_mode,
    input  logic                     enqueue,
    input  slice_count_t             enqueue_count,
    input  logic [WORD_W-1:0]        enqueue_data,
    input  logic                     dequeue,
    input  slice_count_t             dequeue_count,
    output logic [WORD_W-1:0]        dequeue_data,
    output logic [$clog2(DEPTH):0]   avail_count,
    output logic [$clog2(DEPTH):0]   free_count
);

    localparam int PTR_W = $clog2(DEPTH);

    write_req_t                 write_req;
    logic [PTR_W-1:0]           write_ptr;
    logic [DEPTH*SLICE_W-1:0]   cells;

    blit_enqueue_stage #(
        .DEPTH(DEPTH)
    ) enqueue_stage_i (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLK_EN        (CLK_EN),
        .clear         (clear),
        .color_mode    (color_mode),
        .enqueue       (enqueue),
        .enqueue_count (enqueue_count),
        .enqueue_data  (enqueue_data),
        .write_req     (write_req),
        .write_ptr     (write_ptr)
    );

    // Every cell sees the same request and picks its own lane
    for (genvar k = 0; k < DEPTH; k++) begin : g_cell
        blit_slice_cell #(
            .DEPTH(DEPTH),
            .INDEX(k)
        ) slice_cell_i (
            .CLK       (CLK),
            .write_req (write_req),
            .write_ptr (write_ptr),
            .slice     (cells[SLICE_W*k +: SLICE_W])
        );
    end

    blit_dequeue_stage #(
        .DEPTH(DEPTH)
    ) dequeue_stage_i (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLK_EN        (CLK_EN),
        .clear         (clear),
        .color_mode    (color_mode),
        .dequeue       (dequeue),
        .dequeue_count (dequeue_count),
        .cells         (cells),
        .dequeue_data  (dequeue_data)
    );

    blit_fifo_level #(
        .DEPTH(DEPTH)
    ) fifo_level_i (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLK_EN        (CLK_EN),
        .clear         (clear),
        .color_mode    (color_mode),
        .enqueue       (enqueue),
        .enqueue_count (enqueue_count),
        .dequeue       (dequeue),
        .dequeue_count (dequeue_count),
        .avail_count   (avail_count),
        .free_count    (free_count)
    );

endmodule

// File: hw/blit_fifo_level.sv
`timescale 1ns/1ps

module blit_fifo_level
    import blit_fifo_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     CLK_EN,
    input  logic                     clear,
    input  color_mode_e              color_mode,
    input  logic                     enqueue,
    input  slice_count_t             enqueue_count,
    input  logic                     dequeue,
    input  slice_count_t             dequeue_count,
    output logic [$clog2(DEPTH):0]   avail_count,
    output logic [$clog2(DEPTH):0]   free_count
);

    localparam int LVL_W = $clog2(DEPTH) + 1;

    logic [LVL_W-1:0] enq_pixels;
    logic [LVL_W-1:0] deq_pixels;
    logic [LVL_W-1:0] capacity;

    assign enq_pixels = (CLK_EN && enqueue) ? LVL_W'(enqueue_count) : '0;
    assign deq_pixels = (CLK_EN && dequeue) ? LVL_W'(dequeue_count) : '0;

    // Ring size in pixels for the current mode
    assign capacity = LVL_W'(DEPTH / int'(slices_per_pixel(color_mode)));

    // Level counts pixels at the strobe edge, ahead of the actual cell write
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            avail_count <= '0;
        end else if (clear) begin
            avail_count <= '0;
        end else begin
            avail_count <= avail_count + enq_pixels - deq_pixels;
        end
    end

    // Free space trails the level by one cycle
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            free_count <= '0;
        end else if (clear) begin
            free_count <= '0;
        end else begin
            free_count <= capacity - avail_count;
        end
    end

    // No back-pressure exists, so the client has to respect both levels
    a_no_overflow : assert property (
        @(posedge CLK) disable iff (!RESET_n)
        (CLK_EN && enqueue && !clear) |-> (enqueue_count <= free_count)
    ) else $error("enqueue of %0d pixels with %0d free", enqueue_count, free_count);

    a_no_underflow : assert property (
        @(posedge CLK) disable iff (!RESET_n)
        (CLK_EN && dequeue && !clear) |-> (dequeue_count <= avail_count)
    ) else $error("dequeue of %0d pixels with %0d stored", dequeue_count, avail_count);

endmodule

// File: hw/blit_dequeue_stage.sv
`timescale 1ns/1ps

module blit_dequeue_stage
    import blit_fifo_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic                       CLK,
    input  logic                       RESET_n,
    input  logic                       CLK_EN,
    input  logic                       clear,
    input  color_mode_e                color_mode,
    input  logic                       dequeue,
    input  slice_count_t               dequeue_count,
    input  logic [DEPTH*SLICE_W-1:0]   cells,
    output logic [WORD_W-1:0]          dequeue_data
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0]                  read_ptr;
    logic [2*$bits(slice_count_t)-1:0] advance;
    logic [WORD_W-1:0]                 gathered;
    logic                              take;

    assign take    = CLK_EN && dequeue;
    assign advance = dequeue_count * slices_per_pixel(color_mode);

    // Sixteen consecutive cells from the read pointer, oldest slice on top
    always_comb begin
        logic [PTR_W-1:0] idx;
        gathered = '0;
        for (int i = 0; i < LANES; i++) begin
            idx = read_ptr + PTR_W'(i);
            gathered[WORD_W-1-SLICE_W*i -: SLICE_W] = cells[SLICE_W*idx +: SLICE_W];
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            read_ptr <= '0;
        end else if (clear) begin
            read_ptr <= '0;
        end else if (take) begin
            read_ptr <= read_ptr + PTR_W'(advance);
        end
    end

    // Output word holds its value until the next dequeue
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            dequeue_data <= '0;
        end else if (clear) begin
            dequeue_data <= '0;
        end else if (take) begin
            dequeue_data <= gathered;
        end
    end

    // The pointer must not skip more slices than were returned in the word
    a_dequeue_fits_word : assert property (
        @(posedge CLK) disable iff (!RESET_n)
        (take && !clear) |-> (advance <= LANES)
    ) else $error("dequeue of %0d slices exceeds one data word", advance);

endmodule

// File: hw/blit_slice_cell.sv
`timescale 1ns/1ps

module blit_slice_cell
    import blit_fifo_pkg::*;
#(
    parameter int DEPTH = 32,
    parameter int INDEX = 0
) (
    input  logic                       CLK,
    input  write_req_t                 write_req,
    input  logic [$clog2(DEPTH)-1:0]   write_ptr,
    output logic [SLICE_W-1:0]         slice
);

    localparam int PTR_W  = $clog2(DEPTH);
    localparam int LANE_W = $clog2(LANES);

    // Position of this cell inside the pending write, wrapping with the ring
    logic [PTR_W-1:0]  lane;
    logic [LANE_W-1:0] lane_idx;
    logic              hit;
    logic [SLICE_W-1:0] lane_slice;

    assign lane     = PTR_W'(INDEX) - write_ptr;
    assign lane_idx = lane[LANE_W-1:0];
    assign hit      = (lane < write_req.slice_count);

    // Lane 0 is the most significant slice of the enqueued word
    assign lane_slice = write_req.data[WORD_W-1-SLICE_W*lane_idx -: SLICE_W];

    // Storage cell, it keeps its slice until the ring comes round again
    always_ff @(posedge CLK) begin
        if (hit) begin
            slice <= lane_slice;
        end
    end

endmodule

// File: hw/blit_enqueue_stage.sv
`timescale 1ns/1ps

module blit_enqueue_stage
    import blit_fifo_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic                       CLK,
    input  logic                       RESET_n,
    input  logic                       CLK_EN,
    input  logic                       clear,
    input  color_mode_e                color_mode,
    input  logic                       enqueue,
    input  slice_count_t               enqueue_count,
    input  logic [WORD_W-1:0]          enqueue_data,
    output write_req_t                 write_req,
    output logic [$clog2(DEPTH)-1:0]   write_ptr
);

    localparam int PTR_W = $clog2(DEPTH);

    // Full-width product so that an oversized request is still visible
    logic [2*$bits(slice_count_t)-1:0] scaled;

    assign scaled = enqueue_count * slices_per_pixel(color_mode);

    // The request is captured together with its data at the strobe edge.
    // On the next edge the cells take it and the pointer moves past it
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            write_req <= '0;
            write_ptr <= '0;
        end else if (clear) begin
            write_req <= '0;
            write_ptr <= '0;
        end else begin
            write_ptr <= write_ptr + PTR_W'(write_req.slice_count);
            if (CLK_EN && enqueue) begin
                write_req.slice_count <= slice_count_t'(scaled);
                write_req.data        <= enqueue_data;
            end else begin
                // No strobe leaves the data alone, only the count matters
                write_req.slice_count <= '0;
            end
        end
    end

    // One strobe may never carry more slices than a data word holds
    a_enqueue_fits_word : assert property (
        @(posedge CLK) disable iff (!RESET_n)
        (CLK_EN && enqueue && !clear) |-> (scaled <= LANES)
    ) else $error("enqueue of %0d slices exceeds one data word", scaled);

endmodule

// File: hw/blit_fifo_pkg.sv
package blit_fifo_pkg;

    // Colour mode of the drawing engine, encoded as in the mode register
    typedef enum logic [1:0] {
        CLRM_2BPP  = 2'd0,
        CLRM_4BPP  = 2'd1,
        CLRM_8BPP  = 2'd2,
        CLRM_16BPP = 2'd3
    } color_mode_e;

    // The ring stores 2-bit slices and a data word carries 16 of them
    localparam int SLICE_W = 2;
    localparam int LANES   = 16;
    localparam int WORD_W  = SLICE_W * LANES;

    // Count of slices or pixels in one strobe, 0 to 16
    typedef logic [4:0] slice_count_t;

    // Pending write towards the slice cells
    // A slice_count of zero means that no cell is written
    typedef struct packed {
        slice_count_t        slice_count;
        logic [WORD_W-1:0]   data;
    } write_req_t;

    // Number of 2-bit slices that make up one pixel in the given mode
    function automatic slice_count_t slices_per_pixel(color_mode_e mode);
        case (mode)
            CLRM_2BPP: begin
                return slice_count_t'(1);
            end
            CLRM_4BPP: begin
                return slice_count_t'(2);
            end
            CLRM_8BPP: begin
                return slice_count_t'(4);
            end
            CLRM_16BPP: begin
                return slice_count_t'(8);
            end
            default: begin
                return slice_count_t'(1);
            end
        endcase
    endfunction

endpackage
